//--- sim.f
+incdir+hdl
hdl/rng_pkg.sv
hdl/mwc_state_ram.sv
hdl/rng_bus_decode.sv
hdl/mwc_step.sv
hdl/rng_read_mux.sv
hdl/rng_top.sv
testbench/tb_rng.sv

//--- Makefile
TOP = tb_rng

.PHONY: sim clean

sim:
	verilator --binary --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- testbench/tb_rng.sv
`timescale 1ns/100ps

module tb_rng;

	// ========================================
	// test sizes and watchdog limit
	// ========================================

	localparam int N_STREAMS = 8;
	localparam int ECHO_OPS = 4;
	localparam int STEP_OPS = 40;
	localparam int MIX_OPS = 64;
	// reset read, stream echo, seeding, stepping, mixing, final sweep, seed reads
	localparam int N_ACCESS = 1 + 2 * ECHO_OPS + 4 * N_STREAMS + 1 + STEP_OPS
		+ 2 * MIX_OPS + 2 * N_STREAMS + 2;
	localparam int CYCLE_LIMIT = 40 * N_ACCESS + 200;

	// multipliers of the two generator halves
	localparam logic [31:0] Z_MULT = 32'd36969;
	localparam logic [31:0] W_MULT = 32'd18000;
	localparam logic [1:0] IDX_RAND = 2'd0;
	localparam logic [1:0] IDX_STREAM = 2'd1;
	localparam logic [1:0] IDX_SEED_Z = 2'd2;
	localparam logic [1:0] IDX_SEED_W = 2'd3;

	logic clk_i = 1'b0;
	logic rst_n_i;
	logic cs_i;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	logic [3:0] adr_i;
	logic [31:0] dat_i;
	logic ack_o;
	logic [31:0] dat_o;

	// reference state of the chosen streams
	logic [9:0] stream_id [N_STREAMS];
	logic [31:0] model_z [N_STREAMS];
	logic [31:0] model_w [N_STREAMS];
	logic [31:0] lfsr_state = 32'h1d42;
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	rng_top uut (
		.clk_i (clk_i), .rst_n_i (rst_n_i),
		.cs_i (cs_i), .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
		.adr_i (adr_i), .dat_i (dat_i), .ack_o (ack_o), .dat_o (dat_o)
	);

	always #4 clk_i = ~clk_i;

	// watchdog
	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	// fibonacci lfsr x^32+x^22+x^2+x+1, one step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		logic fb;
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// mult * low half + high half
	function automatic logic [31:0] mwc_next(input logic [31:0] s, input logic [31:0] mult);
		return mult * {16'd0, s[15:0]} + {16'd0, s[31:16]};
	endfunction

	task automatic check_val(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	// ========================================
	// bus access
	// ========================================

	task automatic bus_access(input logic we, input logic [1:0] idx, input logic [31:0] wdata,
		input int hold, output logic [31:0] rdata);
		@(posedge clk_i);
		cs_i <= 1'b1;
		cyc_i <= 1'b1;
		stb_i <= 1'b1;
		we_i <= we;
		adr_i <= {idx, 2'b00};
		dat_i <= wdata;
		@(posedge clk_i);
		while (ack_o !== 1'b1)
			@(posedge clk_i);
		rdata = dat_o;
		// held access keeps ack up
		repeat (hold) begin
			@(posedge clk_i);
			check_val("ack_o", {31'd0, ack_o}, 32'd1);
		end
		cs_i <= 1'b0;
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		we_i <= 1'b0;
		// ack low one cycle after the drop, read data back to zero after that
		repeat (2) @(posedge clk_i);
		check_val("ack_o", {31'd0, ack_o}, 32'd0);
		repeat (2) @(posedge clk_i);
		check_val("dat_o", dat_o, 32'd0);
	endtask

	task automatic select_stream(input int k);
		logic [31:0] rd;
		bus_access(1'b1, IDX_STREAM, {22'd0, stream_id[k]}, 0, rd);
	endtask

	// random word is z low half on top plus w
	task automatic check_rand(input int k);
		logic [31:0] rd;
		bus_access(1'b0, IDX_RAND, 32'd0, 0, rd);
		check_val("dat_o", rd, {model_z[k][15:0], 16'd0} + model_w[k]);
	endtask

	task automatic step_stream(input int k, input int hold);
		logic [31:0] rd;
		bus_access(1'b1, IDX_RAND, random_bits(32), hold, rd);
		model_z[k] = mwc_next(model_z[k], Z_MULT);
		model_w[k] = mwc_next(model_w[k], W_MULT);
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial begin
		logic [31:0] rd;
		logic [31:0] val;
		logic dup;
		int i;
		int j;
		int k;
		cs_i <= 1'b0;
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		we_i <= 1'b0;
		adr_i <= 4'd0;
		dat_i <= 32'd0;
		rst_n_i <= 1'b0;
		repeat (3) @(posedge clk_i);
		rst_n_i <= 1'b1;
		@(posedge clk_i);
		// reset values
		check_val("ack_o", {31'd0, ack_o}, 32'd0);
		check_val("dat_o", dat_o, 32'd0);
		bus_access(1'b0, IDX_STREAM, 32'd0, 0, rd);
		check_val("dat_o", rd, 32'd0);
		// stream register echoes the low 10 bits
		for (i = 0; i < ECHO_OPS; i++) begin
			val = random_bits(32);
			bus_access(1'b1, IDX_STREAM, val, 0, rd);
			bus_access(1'b0, IDX_STREAM, 32'd0, 0, rd);
			check_val("dat_o", rd, {22'd0, val[9:0]});
		end
		// distinct streams, then seed each one
		for (i = 0; i < N_STREAMS; i++) begin
			do begin
				val = random_bits(10);
				dup = 1'b0;
				for (j = 0; j < i; j++)
					if (stream_id[j] == val[9:0])
						dup = 1'b1;
			end while (dup);
			stream_id[i] = val[9:0];
		end
		for (i = 0; i < N_STREAMS; i++) begin
			select_stream(i);
			model_z[i] = random_bits(32);
			model_w[i] = random_bits(32);
			bus_access(1'b1, IDX_SEED_Z, model_z[i], 0, rd);
			bus_access(1'b1, IDX_SEED_W, model_w[i], 0, rd);
			check_rand(i);
		end
		// one stream, steps with random hold mixed with reads
		select_stream(0);
		for (i = 0; i < STEP_OPS; i++) begin
			val = random_bits(1);
			if (val[0])
				step_stream(0, int'(random_bits(3)));
			else
				check_rand(0);
		end
		// interleaved work over all streams
		for (i = 0; i < MIX_OPS; i++) begin
			k = int'(random_bits(3));
			select_stream(k);
			val = random_bits(2);
			case (val[1:0])
				2'd2: check_rand(k);
				2'd3: begin
					model_z[k] = random_bits(32);
					bus_access(1'b1, IDX_SEED_Z, model_z[k], 0, rd);
				end
				default: step_stream(k, 0);
			endcase
		end
		// every stream still matches its own model
		for (i = 0; i < N_STREAMS; i++) begin
			select_stream(i);
			check_rand(i);
		end
		// seed registers are write only
		bus_access(1'b0, IDX_SEED_Z, 32'd0, 0, rd);
		check_val("dat_o", rd, 32'd0);
		bus_access(1'b0, IDX_SEED_W, 32'd0, 0, rd);
		check_val("dat_o", rd, 32'd0);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- hdl/rng_top.sv
`timescale 1ns/100ps
`include "rng_settings.svh"

module rng_top (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic cs_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [`RNG_ADR_BITS-1:0] adr_i,
	input  logic [`RNG_DATA_BITS-1:0] dat_i,
	output logic ack_o,
	output logic [`RNG_DATA_BITS-1:0] dat_o
);
	import rng_pkg::*;

	// decode to execute
	logic step;
	logic seed_z;
	logic seed_w;
	logic [`RNG_DATA_BITS-1:0] seed_dat;
	logic [`RNG_STREAM_BITS-1:0] stream;
	// decode and execute to result
	logic rd_en;
	reg_idx_e rd_sel;
	logic [`RNG_DATA_BITS-1:0] z_word;
	logic [`RNG_DATA_BITS-1:0] w_word;

	// ========================================
	// pipeline
	// ========================================

	rng_bus_decode u_decode (
		.clk_i (clk_i), .rst_n_i (rst_n_i),
		.cs_i (cs_i), .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
		.adr_i (adr_i), .dat_i (dat_i), .ack_o (ack_o),
		.rd_en_o (rd_en), .step_o (step), .seed_z_o (seed_z), .seed_w_o (seed_w),
		.rd_sel_o (rd_sel), .stream_o (stream), .seed_dat_o (seed_dat)
	);

	mwc_step u_step (
		.clk_i (clk_i), .rst_n_i (rst_n_i),
		.step_i (step), .seed_z_i (seed_z), .seed_w_i (seed_w),
		.seed_dat_i (seed_dat), .stream_i (stream),
		.z_o (z_word), .w_o (w_word)
	);

	rng_read_mux u_result (
		.clk_i (clk_i), .rst_n_i (rst_n_i),
		.rd_en_i (rd_en), .rd_sel_i (rd_sel),
		.z_i (z_word), .w_i (w_word), .stream_i (stream),
		.dat_o (dat_o)
	);

endmodule

//--- hdl/rng_read_mux.sv
`timescale 1ns/100ps
`include "rng_settings.svh"

module rng_read_mux (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic rd_en_i,
	input  rng_pkg::reg_idx_e rd_sel_i,
	input  logic [`RNG_DATA_BITS-1:0] z_i,
	input  logic [`RNG_DATA_BITS-1:0] w_i,
	input  logic [`RNG_STREAM_BITS-1:0] stream_i,
	output logic [`RNG_DATA_BITS-1:0] dat_o
);
	import rng_pkg::*;

	mwc_word_u z_view;
	logic [`RNG_DATA_BITS-1:0] rand_word;

	// ========================================
	// result
	// ========================================

	// z value half moved to the top, plus the full w word
	assign z_view.word = z_i;
	assign rand_word = {z_view.h.value, 16'd0} + w_i;

	// registered read data, zero when no read is selected
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			dat_o <= '0;
		end else if (rd_en_i) begin
			case (rd_sel_i)
				REG_RAND:   dat_o <= rand_word;
				REG_STREAM: dat_o <= {{(`RNG_DATA_BITS-`RNG_STREAM_BITS){1'b0}}, stream_i};
				// seeds are write only
				default:    dat_o <= '0;
			endcase
		end else begin
			dat_o <= '0;
		end
	end

endmodule

//--- hdl/mwc_step.sv
`timescale 1ns/100ps
`include "rng_settings.svh"

module mwc_step (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic step_i,
	input  logic seed_z_i,
	input  logic seed_w_i,
	input  logic [`RNG_DATA_BITS-1:0] seed_dat_i,
	input  logic [`RNG_STREAM_BITS-1:0] stream_i,
	output logic [`RNG_DATA_BITS-1:0] z_o,
	output logic [`RNG_DATA_BITS-1:0] w_o
);
	import rng_pkg::*;

	mwc_word_u z_cur;
	mwc_word_u w_cur;
	logic [`RNG_DATA_BITS-1:0] z_rdat;
	logic [`RNG_DATA_BITS-1:0] w_rdat;
	logic [`RNG_DATA_BITS-1:0] z_next;
	logic [`RNG_DATA_BITS-1:0] w_next;
	logic [`RNG_DATA_BITS-1:0] z_wdat;
	logic [`RNG_DATA_BITS-1:0] w_wdat;
	logic z_wr;
	logic w_wr;

	// ========================================
	// next state
	// ========================================

	// current state of the selected stream, split into halves
	assign z_cur.word = z_rdat;
	assign w_cur.word = w_rdat;

	// mult * value + carry, widened to the full word
	// worst case 36969 * 65535 + 65535 still fits in 32 bits
	assign z_next = {16'd0, `RNG_Z_MULT} * {16'd0, z_cur.h.value} + {16'd0, z_cur.h.carry};
	assign w_next = {16'd0, `RNG_W_MULT} * {16'd0, w_cur.h.value} + {16'd0, w_cur.h.carry};

	// step writes both rams, a seed only its own
	assign z_wr = step_i | seed_z_i;
	assign w_wr = step_i | seed_w_i;
	assign z_wdat = step_i ? z_next : seed_dat_i;
	assign w_wdat = step_i ? w_next : seed_dat_i;

	// ========================================
	// state storage
	// ========================================

	mwc_state_ram u_z_ram (
		.clk_i  (clk_i),
		.wr_i   (z_wr),
		.adr_i  (stream_i),
		.wdat_i (z_wdat),
		.rdat_o (z_rdat)
	);

	mwc_state_ram u_w_ram (
		.clk_i  (clk_i),
		.wr_i   (w_wr),
		.adr_i  (stream_i),
		.wdat_i (w_wdat),
		.rdat_o (w_rdat)
	);

	assign z_o = z_cur.word;
	assign w_o = w_cur.word;

	// decode issues one strobe per access, never a step mixed with a seed
	a_no_step_seed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(step_i && (seed_z_i || seed_w_i)));

endmodule

//--- hdl/rng_bus_decode.sv
`timescale 1ns/100ps
`include "rng_settings.svh"

module rng_bus_decode (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic cs_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [`RNG_ADR_BITS-1:0] adr_i,
	input  logic [`RNG_DATA_BITS-1:0] dat_i,
	output logic ack_o,
	output logic rd_en_o,
	output logic step_o,
	output logic seed_z_o,
	output logic seed_w_o,
	output rng_pkg::reg_idx_e rd_sel_o,
	output logic [`RNG_STREAM_BITS-1:0] stream_o,
	output logic [`RNG_DATA_BITS-1:0] seed_dat_o
);
	import rng_pkg::*;

	logic access;
	logic req_q;
	logic we_q;
	reg_idx_e idx_q;
	logic [`RNG_DATA_BITS-1:0] dat_q;
	logic wr_req;
	logic wr_req_d;
	logic wr_pulse;

	// ========================================
	// request capture
	// ========================================

	// access present while all three strobes are high
	assign access = cs_i & cyc_i & stb_i;

	// control side, edge 1 registers the request
	// ack follows one edge later if the access is still there
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			req_q <= 1'b0;
			ack_o <= 1'b0;
			wr_req_d <= 1'b0;
		end else begin
			req_q <= access;
			ack_o <= req_q & access;
			wr_req_d <= wr_req;
		end
	end

	// payload side, held stable by the master
	always_ff @(posedge clk_i) begin
		we_q <= we_i;
		idx_q <= reg_idx_e'(adr_i[3:2]);
		dat_q <= dat_i;
	end

	// read path: level while a read is registered
	assign rd_en_o = req_q & ~we_q;
	assign rd_sel_o = idx_q;
	assign seed_dat_o = dat_q;

	// ========================================
	// write strobes
	// ========================================

	// rising edge of the registered write, so a held write acts once
	assign wr_req = req_q & we_q;
	assign wr_pulse = wr_req & ~wr_req_d;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			step_o <= 1'b0;
			seed_z_o <= 1'b0;
			seed_w_o <= 1'b0;
			stream_o <= '0;
		end else begin
			step_o <= wr_pulse && (idx_q == REG_RAND);
			seed_z_o <= wr_pulse && (idx_q == REG_SEED_Z);
			seed_w_o <= wr_pulse && (idx_q == REG_SEED_W);
			// stream number is the low data bits
			if (wr_pulse && (idx_q == REG_STREAM))
				stream_o <= dat_q[`RNG_STREAM_BITS-1:0];
		end
	end

	// ack only ever answers an access seen on the previous cycle
	a_ack_needs_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ack_o |-> $past(access));

	// one strobe at a time, and none lasts past a single cycle
	a_strobe_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({step_o, seed_z_o, seed_w_o}));
	a_strobe_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(step_o | seed_z_o | seed_w_o) |=> !(step_o | seed_z_o | seed_w_o));

endmodule

//--- hdl/mwc_state_ram.sv
`timescale 1ns/100ps
`include "rng_settings.svh"

module mwc_state_ram (
	input  logic clk_i,
	input  logic wr_i,
	input  logic [`RNG_STREAM_BITS-1:0] adr_i,
	input  logic [`RNG_DATA_BITS-1:0] wdat_i,
	output logic [`RNG_DATA_BITS-1:0] rdat_o
);

	// one state word per stream
	logic [`RNG_DATA_BITS-1:0] mem [0:(1 << `RNG_STREAM_BITS)-1];

	logic wr_q;
	logic [`RNG_STREAM_BITS-1:0] adr_q;
	logic [`RNG_DATA_BITS-1:0] wdat_q;

	// ========================================
	// registered port
	// ========================================

	// write request lands here first and commits one edge later
	always_ff @(posedge clk_i) begin
		wr_q <= wr_i;
		adr_q <= adr_i;
		wdat_q <= wdat_i;
	end

	always_ff @(posedge clk_i) begin
		if (wr_q)
			mem[adr_q] <= wdat_q;
	end

	// asynchronous read from the registered address
	assign rdat_o = mem[adr_q];

	a_commit_adr_known: assert property (@(posedge clk_i)
		wr_q |-> !$isunknown(adr_q));

endmodule

//--- hdl/rng_pkg.sv
`include "rng_settings.svh"

package rng_pkg;

	// ========================================
	// state word views
	// ========================================

	// carry in the high half, value in the low half
	typedef struct packed {
		logic [`RNG_DATA_BITS/2-1:0] carry;
		logic [`RNG_DATA_BITS/2-1:0] value;
	} mwc_half_s;

	// one state word, seen whole or as carry/value halves
	typedef union packed {
		logic [`RNG_DATA_BITS-1:0] word;
		mwc_half_s h;
	} mwc_word_u;

	// register index, taken from adr bits 3:2
	typedef enum logic [1:0] {
		REG_RAND   = 2'd0,
		REG_STREAM = 2'd1,
		REG_SEED_Z = 2'd2,
		REG_SEED_W = 2'd3
	} reg_idx_e;

endpackage

//--- hdl/rng_settings.svh
`ifndef RNG_SETTINGS_SVH
`define RNG_SETTINGS_SVH

// ========================================
// generator constants
// ========================================

// marsaglia multiply-with-carry multipliers, 16 bits each
`define RNG_Z_MULT 16'd36969
`define RNG_W_MULT 16'd18000

// ========================================
// sizes
// ========================================

// stream address width, 1024 streams
`define RNG_STREAM_BITS 10
// data bus and state word width
`define RNG_DATA_BITS 32
// bus address width, register index sits in bits 3:2
`define RNG_ADR_BITS 4

`endif
